// ==== board_ctrl_checker.sv ====
module board_ctrl_checker (
    input logic fpga_100m_clk, // System clock
    input logic arst_n,        // Async reset, active low
    input logic opb_re,        // Bus read strobe
    input logic opb_we,        // Bus write strobe
    input logic pulse_20khz,   // 20 kHz debug strobe
    input logic pulse_2khz     // 2 kHz debug strobe
);

    int unsigned n_fail = 0; // Assertion failures, read by the testbench top

    a_20k_width: assert property (@(posedge fpga_100m_clk) disable iff (!arst_n)
        pulse_20khz |=> !pulse_20khz)
        else begin
            $error("pulse_20khz is wider than one cycle");
            n_fail++;
        end

    a_2k_width: assert property (@(posedge fpga_100m_clk) disable iff (!arst_n)
        pulse_2khz |=> !pulse_2khz)
        else begin
            $error("pulse_2khz is wider than one cycle");
            n_fail++;
        end

    // 2 kHz strobe rides on a 20 kHz one
    a_2k_on_20k: assert property (@(posedge fpga_100m_clk) disable iff (!arst_n)
        pulse_2khz |-> pulse_20khz)
        else begin
            $error("pulse_2khz without a pulse_20khz in the same cycle");
            n_fail++;
        end

    a_bus_excl: assert property (@(posedge fpga_100m_clk) disable iff (!arst_n)
        !(opb_re && opb_we))
        else begin
            $error("opb_re and opb_we asserted together");
            n_fail++;
        end

endmodule

bind board_ctrl_top board_ctrl_checker i_checker (
    .fpga_100m_clk (fpga_100m_clk),
    .arst_n        (arst_n),
    .opb_re        (opb_re),
    .opb_we        (opb_we),
    .pulse_20khz   (pulse_20khz),
    .pulse_2khz    (pulse_2khz)
);

// ==== board_ctrl_pkg.sv ====
package board_ctrl_pkg;

    // Register bus geometry
    localparam int OPB_DATA_W = 32; // Data path width
    localparam int OPB_ADDR_W = 16; // Byte address width

    // Register select carried from decode to the register stage
    typedef enum logic [2:0] {
        REG_NONE     = 3'd0, // Unmapped or idle
        REG_SP1      = 3'd1, // Scratchpad 1
        REG_SP2      = 3'd2, // Scratchpad 2
        REG_CLK_BASE = 3'd3, // Base prescale to 200 kHz
        REG_CLK_SLOW = 3'd4, // Slow divider from 2 kHz
        REG_WD_CTRL  = 3'd5, // Watchdog enable and tick count
        REG_ID       = 3'd6  // Read-only board ID
    } reg_sel_e;

    // Register map, full byte addresses
    localparam logic [OPB_ADDR_W-1:0] ADDR_SP1      = 16'h0000;
    localparam logic [OPB_ADDR_W-1:0] ADDR_SP2      = 16'h0004;
    localparam logic [OPB_ADDR_W-1:0] ADDR_CLK_BASE = 16'h0010;
    localparam logic [OPB_ADDR_W-1:0] ADDR_CLK_SLOW = 16'h0014;
    localparam logic [OPB_ADDR_W-1:0] ADDR_WD_CTRL  = 16'h0020;
    localparam logic [OPB_ADDR_W-1:0] ADDR_ID       = 16'h003C;

    // Board identification word
    localparam logic [OPB_DATA_W-1:0] BOARD_ID = 32'h0BC1_0100;

    // Timebase reset values
    localparam logic [15:0] CLK_BASE_DEFAULT = 16'd500;  // 100 MHz down to 200 kHz
    localparam logic [15:0] CLK_SLOW_DEFAULT = 16'd1000; // 2 kHz down to 1 Hz level toggle

    // Fixed ratios against the 200 kHz tick
    localparam logic [7:0] RATIO_20K   = 8'd10; // 200 kHz to 20 kHz
    localparam logic [7:0] RATIO_2K    = 8'd10; // 20 kHz to 2 kHz
    localparam logic [7:0] RATIO_100US = 8'd20; // 200 kHz to 10 kHz

    // Watchdog reset values
    localparam logic [7:0] WD_TICKS_DEFAULT = 8'd5; // 100 us ticks per toggle
    localparam logic       WD_EN_DEFAULT    = 1'b1; // Trigger runs out of reset

    // Watchdog control word layout
    localparam int WD_EN_BIT    = 0; // Enable bit
    localparam int WD_TICKS_LSB = 8; // Tick count field, 8 bits wide

endpackage

// ==== board_ctrl_top.sv ====
module board_ctrl_top import board_ctrl_pkg::*; (
    input  logic                  fpga_100m_clk, // System clock, 100 MHz
    input  logic                  arst_n,        // Async reset, active low
    input  logic                  opb_re,        // Bus read strobe
    input  logic                  opb_we,        // Bus write strobe
    input  logic [OPB_ADDR_W-1:0] opb_addr,      // Bus byte address
    input  logic [OPB_DATA_W-1:0] opb_di,        // Bus write data
    output logic [OPB_DATA_W-1:0] opb_do,        // Bus read data
    output logic                  pulse_20khz,   // 20 kHz debug strobe
    output logic                  pulse_2khz,    // 2 kHz debug strobe
    output logic                  power_good,    // Slow square wave
    output logic                  wd_trig        // External watchdog trigger
);

    // Decode to register stage
    logic                  req_re;
    logic                  req_we;
    reg_sel_e              req_sel;
    logic [OPB_DATA_W-1:0] req_wdata;

    // Register stage to timebase and watchdog
    logic [15:0]           clk_base;
    logic [15:0]           clk_slow;
    logic                  tb_restart;
    logic                  wd_en;
    logic [7:0]            wd_ticks;
    logic                  tick_100us; // Timebase to watchdog

    opb_decode i_opb_decode (
        .fpga_100m_clk (fpga_100m_clk),
        .arst_n        (arst_n),
        .opb_re        (opb_re),
        .opb_we        (opb_we),
        .opb_addr      (opb_addr),
        .opb_di        (opb_di),
        .req_re        (req_re),
        .req_we        (req_we),
        .req_sel       (req_sel),
        .req_wdata     (req_wdata)
    );

    ctrl_regs i_ctrl_regs (
        .fpga_100m_clk (fpga_100m_clk),
        .arst_n        (arst_n),
        .req_re        (req_re),
        .req_we        (req_we),
        .req_sel       (req_sel),
        .req_wdata     (req_wdata),
        .opb_do        (opb_do),
        .clk_base      (clk_base),
        .clk_slow      (clk_slow),
        .tb_restart    (tb_restart),
        .wd_en         (wd_en),
        .wd_ticks      (wd_ticks)
    );

    pulse_gen i_pulse_gen (
        .fpga_100m_clk (fpga_100m_clk),
        .arst_n        (arst_n),
        .clk_base      (clk_base),
        .clk_slow      (clk_slow),
        .tb_restart    (tb_restart),
        .tick_100us    (tick_100us),
        .pulse_20khz   (pulse_20khz),
        .pulse_2khz    (pulse_2khz),
        .power_good    (power_good)
    );

    wd_trigger i_wd_trigger (
        .fpga_100m_clk (fpga_100m_clk),
        .arst_n        (arst_n),
        .tick_100us    (tick_100us),
        .wd_en         (wd_en),
        .wd_ticks      (wd_ticks),
        .wd_trig       (wd_trig)
    );

endmodule

// ==== ctrl_regs.sv ====
module ctrl_regs import board_ctrl_pkg::*; (
    input  logic                  fpga_100m_clk, // System clock, 100 MHz
    input  logic                  arst_n,        // Async reset, active low
    input  logic                  req_re,        // Read request from decode
    input  logic                  req_we,        // Write request from decode
    input  reg_sel_e              req_sel,       // Target register
    input  logic [OPB_DATA_W-1:0] req_wdata,     // Write data
    output logic [OPB_DATA_W-1:0] opb_do,        // Read data, held until next read
    output logic [15:0]           clk_base,      // Base prescale to 200 kHz
    output logic [15:0]           clk_slow,      // Slow divider from 2 kHz
    output logic                  tb_restart,    // Timebase restart strobe
    output logic                  wd_en,         // Watchdog enable
    output logic [7:0]            wd_ticks       // 100 us ticks per toggle
);

    logic [OPB_DATA_W-1:0] sp1;      // Scratchpad 1
    logic [OPB_DATA_W-1:0] sp2;      // Scratchpad 2
    logic [OPB_DATA_W-1:0] rd_mux;   // Read mux result
    logic [OPB_DATA_W-1:0] wd_word;  // Watchdog control as seen on the bus
    logic                  clk_wr;   // Write hits a clock register

    // Enable in bit 0, tick count in bits 15:8
    always_comb begin
        wd_word                                = '0;
        wd_word[WD_EN_BIT]                     = wd_en;
        wd_word[WD_TICKS_LSB +: 8]             = wd_ticks;
    end

    assign clk_wr = req_we && ((req_sel == REG_CLK_BASE) || (req_sel == REG_CLK_SLOW));

    // Read mux, unmapped reads give zero
    always_comb begin
        case (req_sel)
            REG_SP1:      rd_mux = sp1;
            REG_SP2:      rd_mux = sp2;
            REG_CLK_BASE: rd_mux = {16'h0000, clk_base}; // Upper half reads zero
            REG_CLK_SLOW: rd_mux = {16'h0000, clk_slow};
            REG_WD_CTRL:  rd_mux = wd_word;
            REG_ID:       rd_mux = BOARD_ID;
            default:      rd_mux = '0;
        endcase
    end

    // Register file writes
    always_ff @(posedge fpga_100m_clk or negedge arst_n) begin
        if (!arst_n) begin
            sp1      <= '0;
            sp2      <= '0;
            clk_base <= CLK_BASE_DEFAULT;
            clk_slow <= CLK_SLOW_DEFAULT;
            wd_en    <= WD_EN_DEFAULT;
            wd_ticks <= WD_TICKS_DEFAULT;
        end else if (req_we) begin
            case (req_sel)
                REG_SP1: begin
                    sp1 <= req_wdata;
                end
                REG_SP2: begin
                    sp2 <= req_wdata;
                end
                REG_CLK_BASE: begin
                    clk_base <= req_wdata[15:0]; // Low half only
                end
                REG_CLK_SLOW: begin
                    clk_slow <= req_wdata[15:0];
                end
                REG_WD_CTRL: begin
                    wd_en    <= req_wdata[WD_EN_BIT];
                    wd_ticks <= req_wdata[WD_TICKS_LSB +: 8];
                end
                default: begin
                    // ID and unmapped writes are dropped
                end
            endcase
        end
    end

    // Restart strobe lines up with the new clock value
    always_ff @(posedge fpga_100m_clk or negedge arst_n) begin
        if (!arst_n) begin
            tb_restart <= 1'b0;
        end else begin
            tb_restart <= clk_wr; // One cycle, pulse_gen reloads on the next edge
        end
    end

    // Read data, loaded only on a read
    always_ff @(posedge fpga_100m_clk or negedge arst_n) begin
        if (!arst_n) begin
            opb_do <= '0;
        end else if (req_re) begin
            opb_do <= rd_mux; // Holds between reads
        end
    end

endmodule

// ==== opb_decode.sv ====
module opb_decode import board_ctrl_pkg::*; (
    input  logic                  fpga_100m_clk, // System clock, 100 MHz
    input  logic                  arst_n,        // Async reset, active low
    input  logic                  opb_re,        // Bus read strobe
    input  logic                  opb_we,        // Bus write strobe
    input  logic [OPB_ADDR_W-1:0] opb_addr,      // Bus byte address
    input  logic [OPB_DATA_W-1:0] opb_di,        // Bus write data
    output logic                  req_re,        // Registered read strobe
    output logic                  req_we,        // Registered write strobe
    output reg_sel_e              req_sel,       // Registered register select
    output logic [OPB_DATA_W-1:0] req_wdata      // Registered write data
);

    reg_sel_e addr_sel; // Map lookup of the live address

    // Full address compare, anything else falls to REG_NONE
    always_comb begin
        case (opb_addr)
            ADDR_SP1:      addr_sel = REG_SP1;
            ADDR_SP2:      addr_sel = REG_SP2;
            ADDR_CLK_BASE: addr_sel = REG_CLK_BASE;
            ADDR_CLK_SLOW: addr_sel = REG_CLK_SLOW;
            ADDR_WD_CTRL:  addr_sel = REG_WD_CTRL;
            ADDR_ID:       addr_sel = REG_ID;
            default:       addr_sel = REG_NONE;
        endcase
    end

    // Strobes and select, one request per cycle
    always_ff @(posedge fpga_100m_clk or negedge arst_n) begin
        if (!arst_n) begin
            req_re  <= 1'b0;
            req_we  <= 1'b0;
            req_sel <= REG_NONE;
        end else begin
            req_re  <= opb_re; // Drops back low when idle
            req_we  <= opb_we;
            if (opb_re || opb_we) begin
                req_sel <= addr_sel;
            end else begin
                req_sel <= REG_NONE; // Idle cycle selects nothing
            end
        end
    end

    // Write data only matters alongside req_we
    always_ff @(posedge fpga_100m_clk) begin
        if (opb_we) begin
            req_wdata <= opb_di; // Capture with the write strobe
        end
    end

endmodule

// ==== pulse_gen.sv ====
module pulse_gen import board_ctrl_pkg::*; (
    input  logic        fpga_100m_clk, // System clock, 100 MHz
    input  logic        arst_n,        // Async reset, active low
    input  logic [15:0] clk_base,      // Cycles per 200 kHz tick
    input  logic [15:0] clk_slow,      // 2 kHz strobes per power_good toggle
    input  logic        tb_restart,    // Reload every counter
    output logic        tick_100us,    // 10 kHz strobe for the watchdog
    output logic        pulse_20khz,   // 20 kHz debug strobe
    output logic        pulse_2khz,    // 2 kHz debug strobe
    output logic        power_good     // Slow square wave
);

    logic [15:0] pre_cnt;   // Prescale down-counter
    logic        tick_200k; // Internal 200 kHz strobe
    logic [7:0]  cnt_20k;   // Ratio counter to 20 kHz
    logic [7:0]  cnt_2k;    // Ratio counter to 2 kHz, steps on 20 kHz events
    logic [7:0]  cnt_100us; // Ratio counter to 100 us
    logic [15:0] slow_cnt;  // 2 kHz events per power_good toggle
    logic        fire_20k;  // 20 kHz event this cycle
    logic        fire_2k;   // 2 kHz event this cycle

    // Both derived from the same tick so the 2 kHz strobe lands on a 20 kHz one
    assign fire_20k = tick_200k && (cnt_20k == 8'd0);
    assign fire_2k  = fire_20k && (cnt_2k == 8'd0);

    always_ff @(posedge fpga_100m_clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt     <= CLK_BASE_DEFAULT - 16'd1;
            tick_200k   <= 1'b0;
            cnt_20k     <= RATIO_20K - 8'd1;
            cnt_2k      <= RATIO_2K - 8'd1;
            cnt_100us   <= RATIO_100US - 8'd1;
            slow_cnt    <= CLK_SLOW_DEFAULT - 16'd1;
            tick_100us  <= 1'b0;
            pulse_20khz <= 1'b0;
            pulse_2khz  <= 1'b0;
            power_good  <= 1'b0;
        end else if (tb_restart) begin
            pre_cnt     <= clk_base - 16'd1; // New prescale takes effect here
            tick_200k   <= 1'b0;
            cnt_20k     <= RATIO_20K - 8'd1;
            cnt_2k      <= RATIO_2K - 8'd1;
            cnt_100us   <= RATIO_100US - 8'd1;
            slow_cnt    <= clk_slow - 16'd1;
            tick_100us  <= 1'b0;
            pulse_20khz <= 1'b0;
            pulse_2khz  <= 1'b0;
            power_good  <= 1'b0; // Known phase after restart
        end else begin
            // Prescale, one tick every clk_base cycles
            if (pre_cnt == 16'd0) begin
                pre_cnt   <= clk_base - 16'd1;
                tick_200k <= 1'b1;
            end else begin
                pre_cnt   <= pre_cnt - 16'd1;
                tick_200k <= 1'b0;
            end

            // 20 kHz
            if (tick_200k) begin
                cnt_20k <= (cnt_20k == 8'd0) ? RATIO_20K - 8'd1 : cnt_20k - 8'd1;
            end
            pulse_20khz <= fire_20k;

            // 2 kHz, counts 20 kHz events
            if (fire_20k) begin
                cnt_2k <= (cnt_2k == 8'd0) ? RATIO_2K - 8'd1 : cnt_2k - 8'd1;
            end
            pulse_2khz <= fire_2k;

            // 100 us
            if (tick_200k) begin
                cnt_100us <= (cnt_100us == 8'd0) ? RATIO_100US - 8'd1 : cnt_100us - 8'd1;
            end
            tick_100us <= tick_200k && (cnt_100us == 8'd0);

            // Slow level, toggles every clk_slow 2 kHz events
            if (fire_2k) begin
                if (slow_cnt == 16'd0) begin
                    slow_cnt   <= clk_slow - 16'd1;
                    power_good <= ~power_good;
                end else begin
                    slow_cnt <= slow_cnt - 16'd1;
                end
            end
        end
    end

endmodule

// ==== sim.f ====
board_ctrl_pkg.sv
opb_decode.sv
ctrl_regs.sv
pulse_gen.sv
wd_trigger.sv
board_ctrl_top.sv
board_ctrl_checker.sv
tb_monitor.sv
tb_board_ctrl.sv

// ==== tb_board_ctrl.sv ====
module tb_board_ctrl import board_ctrl_pkg::*; ();

    typedef enum logic {OP_RD, OP_WR} tb_op_e;

    localparam int          MAX_ENTRIES = 32;
    localparam int unsigned TB_BASE     = 4;   // Fast prescale for simulation
    localparam int unsigned TB_SLOW     = 3;
    localparam logic [7:0]  TB_TICKS    = 8'd2;

    logic                  fpga_100m_clk;
    logic                  arst_n;
    logic                  opb_re;
    logic                  opb_we;
    logic [OPB_ADDR_W-1:0] opb_addr;
    logic [OPB_DATA_W-1:0] opb_di;
    logic [OPB_DATA_W-1:0] opb_do;
    logic [OPB_DATA_W-1:0] rd_exp;       // Expected read data for the monitor
    logic                  pulse_20khz;
    logic                  pulse_2khz;
    logic                  power_good;
    logic                  wd_trig;

    tb_op_e                t_op    [MAX_ENTRIES];
    logic [OPB_ADDR_W-1:0] t_addr  [MAX_ENTRIES];
    logic [OPB_DATA_W-1:0] t_wdata [MAX_ENTRIES];
    logic [OPB_DATA_W-1:0] t_exp   [MAX_ENTRIES];
    int unsigned           t_wait  [MAX_ENTRIES]; // Idle cycles after the entry
    int                    n_entries;
    logic [OPB_DATA_W-1:0] sp1_val;
    logic [OPB_DATA_W-1:0] sp2_val;
    int unsigned           limit;
    int unsigned           cycles;
    int unsigned           errs;

    board_ctrl_top i_dut (.*);

    tb_monitor i_mon (.*);

    // Watchdog control word, enable in bit 0 and ticks in 15:8
    function automatic logic [31:0] pack_wd_ctrl(input logic en, input logic [7:0] ticks);
        return {16'h0000, ticks, 7'd0, en};
    endfunction

    task automatic add_entry(input tb_op_e op, input logic [15:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp,
                             input int unsigned wait_cyc);
        t_op[n_entries]    = op;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_exp[n_entries]   = exp;
        t_wait[n_entries]  = wait_cyc;
        n_entries++;
    endtask

    task automatic build_table();
        // Reset defaults, back to back
        add_entry(OP_RD, ADDR_SP1, 0, 0, 0);
        add_entry(OP_RD, ADDR_SP2, 0, 0, 0);
        add_entry(OP_RD, ADDR_CLK_BASE, 0, CLK_BASE_DEFAULT, 0);
        add_entry(OP_RD, ADDR_CLK_SLOW, 0, CLK_SLOW_DEFAULT, 0);
        add_entry(OP_RD, ADDR_WD_CTRL, 0, pack_wd_ctrl(WD_EN_DEFAULT, WD_TICKS_DEFAULT), 0);
        add_entry(OP_RD, ADDR_ID, 0, BOARD_ID, 2);
        // Scratchpads, first read right after its write
        add_entry(OP_WR, ADDR_SP1, sp1_val, 0, 0);
        add_entry(OP_RD, ADDR_SP1, 0, sp1_val, 1);
        add_entry(OP_WR, ADDR_SP2, sp2_val, 0, 2);
        add_entry(OP_RD, ADDR_SP2, 0, sp2_val, 1);
        add_entry(OP_WR, ADDR_ID, ~BOARD_ID, 0, 1); // Read-only
        add_entry(OP_RD, ADDR_ID, 0, BOARD_ID, 1);
        add_entry(OP_WR, 16'h0008, sp1_val ^ sp2_val, 0, 1); // Unmapped
        add_entry(OP_RD, 16'h0008, 0, 0, 2);
        // Back-to-back reads
        add_entry(OP_RD, ADDR_SP2, 0, sp2_val, 0);
        add_entry(OP_RD, ADDR_ID, 0, BOARD_ID, 0);
        add_entry(OP_RD, ADDR_SP1, 0, sp1_val, 0);
        add_entry(OP_RD, ADDR_CLK_SLOW, 0, CLK_SLOW_DEFAULT, 2);
        // Timebase and watchdog at simulation speed
        add_entry(OP_WR, ADDR_CLK_BASE, TB_BASE, 0, 0);
        add_entry(OP_WR, ADDR_CLK_SLOW, TB_SLOW, 0, 0);
        add_entry(OP_WR, ADDR_WD_CTRL, pack_wd_ctrl(1'b1, TB_TICKS), 0, 1);
        add_entry(OP_RD, ADDR_CLK_BASE, 0, TB_BASE, 0);
        add_entry(OP_RD, ADDR_CLK_SLOW, 0, TB_SLOW, 0);
        add_entry(OP_RD, ADDR_WD_CTRL, 0, pack_wd_ctrl(1'b1, TB_TICKS), 3000);
        // Watchdog off, output must stay parked
        add_entry(OP_WR, ADDR_WD_CTRL, pack_wd_ctrl(1'b0, TB_TICKS), 0, 400);
        add_entry(OP_RD, ADDR_WD_CTRL, 0, pack_wd_ctrl(1'b0, TB_TICKS), 2);
    endtask

    task automatic apply_entry(input int i);
        @(posedge fpga_100m_clk);
        opb_re   <= (t_op[i] == OP_RD);
        opb_we   <= (t_op[i] == OP_WR);
        opb_addr <= t_addr[i];
        opb_di   <= t_wdata[i];
        rd_exp   <= t_exp[i];
        repeat (t_wait[i]) begin
            @(posedge fpga_100m_clk);
            opb_re <= 1'b0; // Bus idle
            opb_we <= 1'b0;
        end
    endtask

    initial begin
        fpga_100m_clk = 1'b0;
        forever #2 fpga_100m_clk = ~fpga_100m_clk;
    end

    initial begin
        void'($urandom(32'hfc0b_ead0));
        arst_n    = 1'b0;
        opb_re    = 1'b0;
        opb_we    = 1'b0;
        opb_addr  = '0;
        opb_di    = '0;
        rd_exp    = '0;
        n_entries = 0;
        sp1_val   = $urandom;
        sp2_val   = $urandom;
        build_table();
        // Table length plus two of the slowest interval, the power_good edge
        limit = 2 * TB_SLOW * RATIO_2K * RATIO_20K * TB_BASE + n_entries + 16;
        for (int i = 0; i < n_entries; i++) begin
            limit += t_wait[i];
        end
        repeat (4) @(posedge fpga_100m_clk);
        arst_n <= 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        @(posedge fpga_100m_clk);
        opb_re <= 1'b0;
        opb_we <= 1'b0;
        repeat (4) @(posedge fpga_100m_clk); // Drain the read pipeline
        i_mon.summarize(errs);
        errs += i_dut.i_checker.n_fail;
        if (errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Run guard
    initial begin
        cycles = 0;
        @(posedge fpga_100m_clk);
        while (cycles <= limit) begin
            @(posedge fpga_100m_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tb_monitor.sv ====
module tb_monitor import board_ctrl_pkg::*; (
    input logic                  fpga_100m_clk, // System clock
    input logic                  arst_n,        // Async reset, active low
    input logic                  opb_re,        // Bus read strobe
    input logic                  opb_we,        // Bus write strobe
    input logic [OPB_ADDR_W-1:0] opb_addr,      // Bus address
    input logic [OPB_DATA_W-1:0] opb_di,        // Bus write data
    input logic [OPB_DATA_W-1:0] rd_exp,        // Expected data, travels with opb_re
    input logic [OPB_DATA_W-1:0] opb_do,        // DUT read data
    input logic                  pulse_20khz,
    input logic                  pulse_2khz,
    input logic                  power_good,
    input logic                  wd_trig
);

    int unsigned           cyc;            // Cycles since reset
    int unsigned           n_checks;
    int unsigned           n_errors;
    logic                  pend_v;         // Read taken by decode
    logic                  chk_v;          // Read data loaded last edge
    logic [OPB_DATA_W-1:0] pend_exp;
    logic [OPB_DATA_W-1:0] chk_exp;
    int unsigned           base_m;         // Last written bus values
    int unsigned           slow_m;
    int unsigned           ticks_m;
    logic                  en_m;
    int unsigned           settle;         // Cycles until a write has rippled through
    int unsigned           last_t [4];     // 20k, 2k, power_good, wd_trig
    logic                  have_last [4];
    int unsigned           n_meas [4];
    logic                  pg_q;
    logic                  wd_q;
    int unsigned           hold_cnt;       // Disabled cycles with wd_trig low
    logic                  hold_done;

    function automatic string strobe_name(input int k);
        case (k)
            0:       return "pulse_20khz interval";
            1:       return "pulse_2khz interval";
            2:       return "power_good interval";
            default: return "wd_trig interval";
        endcase
    endfunction

    // Cycles between events, from the last written values
    function automatic int unsigned expected_gap(input int k);
        int unsigned gap_20k;
        gap_20k = RATIO_20K * base_m;
        case (k)
            0:       return gap_20k;
            1:       return RATIO_2K * gap_20k;
            2:       return slow_m * RATIO_2K * gap_20k; // power_good edge to edge
            default: return ticks_m * RATIO_100US * base_m;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, got);
        end else begin
            $display("[ OK ] t=%0t %s = 0x%0h", $time, name, got);
        end
    endtask

    task automatic note_event(input int k);
        if (settle == 0) begin
            if (have_last[k]) begin
                check_value(strobe_name(k), expected_gap(k), cyc - last_t[k]);
                n_meas[k]++;
            end
            last_t[k]    = cyc;
            have_last[k] = 1'b1;
        end
    endtask

    always @(posedge fpga_100m_clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc       = 0;
            n_checks  = 0;
            n_errors  = 0;
            pend_v    = 1'b0;
            chk_v     = 1'b0;
            base_m    = CLK_BASE_DEFAULT;
            slow_m    = CLK_SLOW_DEFAULT;
            ticks_m   = WD_TICKS_DEFAULT;
            en_m      = WD_EN_DEFAULT;
            settle    = 0;
            pg_q      = 1'b0;
            wd_q      = 1'b0;
            hold_cnt  = 0;
            hold_done = 1'b0;
            for (int k = 0; k < 4; k++) begin
                have_last[k] = 1'b0;
                n_meas[k]    = 0;
            end
        end else begin
            cyc++;
            if (chk_v) begin
                check_value("opb_do", chk_exp, opb_do); // Loaded one edge ago
            end
            chk_v    = pend_v;
            chk_exp  = pend_exp;
            pend_v   = opb_re;
            pend_exp = rd_exp;

            if (settle != 0) begin
                settle--;
                for (int k = 0; k < 4; k++) begin
                    have_last[k] = 1'b0; // Restart drops the running interval
                end
            end
            if (pulse_20khz) note_event(0);
            if (pulse_2khz) note_event(1);
            if (power_good !== pg_q) note_event(2);
            if (wd_trig !== wd_q) note_event(3);
            pg_q = power_good;
            wd_q = wd_trig;

            // Disabled watchdog parks its output low
            if (!en_m && settle == 0 && !hold_done) begin
                if (wd_trig !== 1'b0) begin
                    check_value("wd_trig", 32'd0, wd_trig);
                end else begin
                    hold_cnt++;
                    if (hold_cnt == expected_gap(3)) begin
                        n_checks++;
                        hold_done = 1'b1;
                        $display("[ OK ] t=%0t wd_trig low for %0d cycles", $time, hold_cnt);
                    end
                end
            end

            if (opb_we) begin
                settle = 4; // Write, restart, then visible on the ports
                case (opb_addr)
                    ADDR_CLK_BASE: base_m = opb_di[15:0];
                    ADDR_CLK_SLOW: slow_m = opb_di[15:0];
                    ADDR_WD_CTRL: begin
                        en_m     = opb_di[0];
                        ticks_m  = opb_di[15:8];
                        hold_cnt = 0;
                    end
                    default: ;
                endcase
            end
        end
    end

    task automatic summarize(output int unsigned errs);
        errs = n_errors;
        for (int k = 0; k < 4; k++) begin
            if (n_meas[k] == 0) begin
                $display("No %s was measured", strobe_name(k));
                errs++;
            end
        end
        if (!hold_done) begin
            $display("wd_trig was never seen low through a full watchdog interval");
            errs++;
        end
        $display("Checks: %0d, failures: %0d", n_checks, errs);
    endtask

endmodule

// ==== wd_trigger.sv ====
module wd_trigger import board_ctrl_pkg::*; (
    input  logic       fpga_100m_clk, // System clock, 100 MHz
    input  logic       arst_n,        // Async reset, active low
    input  logic       tick_100us,    // Counting strobe from the timebase
    input  logic       wd_en,         // Enable, low parks the trigger
    input  logic [7:0] wd_ticks,      // Ticks per toggle
    output logic       wd_trig        // Level to the external watchdog
);

    logic [7:0] wd_cnt;   // Ticks seen since the last toggle
    logic [7:0] wd_next;  // Count including the current tick
    logic       wd_done;  // Toggle point reached

    assign wd_next = wd_cnt + 8'd1;
    assign wd_done = (wd_next >= wd_ticks); // Also catches a lowered tick count

    always_ff @(posedge fpga_100m_clk or negedge arst_n) begin
        if (!arst_n) begin
            wd_cnt  <= 8'd0;
            wd_trig <= 1'b0;
        end else if (!wd_en) begin
            wd_cnt  <= 8'd0; // Count restarts from zero on re-enable
            wd_trig <= 1'b0; // Held low while disabled
        end else if (tick_100us) begin
            if (wd_done) begin
                wd_cnt  <= 8'd0;
                wd_trig <= ~wd_trig; // Keeps the watchdog alive
            end else begin
                wd_cnt <= wd_next;
            end
        end
    end

endmodule
